//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module spiPeripheralTb -f sim.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim.f
source/spiPeriphPkg.sv
source/spiSerialSlave.sv
source/spiRegisterBank.sv
source/cursorTracker.sv
source/spiPeripheralTop.sv
test/spiPeripheral_props.sv
test/spiPeripheralChecker.sv
test/spiPeripheralTb.sv

//--- source/cursorTracker.sv
// Cursor tracker counting step events and walking an X/Y position across a frame
`timescale 1ns/10ps

module cursorTracker #(
	parameter int frameWidth  = 160,    // At most 256
	parameter int frameHeight = 120     // At most 256
) (
	input  logic       theClock,
	input  logic       SPI_counter_reset,
	input  logic       stepPulse,
	input  logic [7:0] configBits,
	output logic [7:0] stepCount,
	output logic [7:0] posX,
	output logic [7:0] posY
);
	import spiPeriphPkg::*;

	localparam logic [7:0] lastX = 8'(frameWidth - 1);
	localparam logic [7:0] lastY = 8'(frameHeight - 1);

	logic stepSeen;
	logic stepTaken;

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
			stepSeen <= 1'b0;
		else
			stepSeen <= stepPulse;    // Each sampled high cycle is one step
	end

	assign stepTaken = stepSeen & configBits[cfgStepEnable];

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			stepCount <= 8'h00;
			posX      <= 8'h00;
			posY      <= 8'h00;
		end
		else if (configBits[cfgClear])
		begin
			stepCount <= 8'h00;       // Clear wins over a pending step
			posX      <= 8'h00;
			posY      <= 8'h00;
		end
		else if (stepTaken)
		begin
			stepCount <= stepCount + 8'd1;  // Free running, wraps at 256
			if (posX == lastX)
			begin
				posX <= 8'h00;
				posY <= (posY == lastY) ? 8'h00 : posY + 8'd1;
			end
			else
				posX <= posX + 8'd1;
		end
	end

endmodule

//--- source/spiPeriphPkg.sv
// SPI peripheral shared types: frame states, register map, transfer and pixel structs
package spiPeriphPkg;

	// Frame FSM, one wait/shift group per byte
	typedef enum logic [3:0]
	{
		idle,                      // Chip select high or frame finished
		addrStart,                 // Clear bit counter for command byte
		addrWaitHigh,              // Wait for synced spiClk rise
		addrShift,                 // Sample one command bit
		addrWaitLow,               // Wait for synced spiClk fall
		dataStart,                 // Load read data, clear bit counter
		dataWaitHigh,
		dataShift,                 // Sample one data bit, advance sdo
		dataWaitLow,
		frameEnd                   // One-cycle frame strobe
	} spiState;

	// Register map, command bits 6..0
	typedef enum logic [6:0]
	{
		regConfig  = 7'h00,
		regCounter = 7'h02,        // Read only
		regPosX    = 7'h03,        // Read only
		regPosY    = 7'h04,        // Read only
		regPixelR  = 7'h12,
		regPixelG  = 7'h13,
		regPixelB  = 7'h14,
		regLed     = 7'h16
	} regAddr;

	// One complete frame as seen by the register bank
	typedef struct packed
	{
		logic       write;         // Command bit 7
		regAddr     addr;
		logic [7:0] data;          // Byte shifted in during the data phase
	} spiTransfer;

	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixelRgb;

	localparam logic [7:0] unmappedValue = 8'h0f;   // Read value of unknown addresses

	localparam int cfgStepEnable = 0;   // Config bit: count step events
	localparam int cfgClear      = 1;   // Config bit: hold tracker at zero

endpackage

//--- source/spiPeripheralTop.sv
// SPI peripheral top level joining the serial slave, register bank and cursor tracker
`timescale 1ns/10ps

module spiPeripheralTop #(
	parameter int frameWidth  = 160,
	parameter int frameHeight = 120
) (
	input  logic                  theClock,
	input  logic                  SPI_counter_reset,
	input  logic                  spiClk,
	input  logic                  spiCs,        // Active low
	input  logic                  spiSdi,
	input  logic                  stepPulse,
	output logic                  spiSdo,
	output logic [7:0]            configBits,
	output logic [7:0]            led,
	output spiPeriphPkg::pixelRgb pixel,
	output logic                  irq
);
	import spiPeriphPkg::*;

	regAddr     frameAddr;
	spiTransfer frame;
	logic       frameDone;
	logic [7:0] readData;
	logic [7:0] stepCount;
	logic [7:0] posX;
	logic [7:0] posY;

	spiSerialSlave slave (
		.theClock          (theClock),
		.SPI_counter_reset (SPI_counter_reset),
		.spiClk            (spiClk),
		.spiCs             (spiCs),
		.spiSdi            (spiSdi),
		.readData          (readData),
		.spiSdo            (spiSdo),
		.frameDone         (frameDone),
		.frameAddr         (frameAddr),
		.frame             (frame)
	);

	spiRegisterBank bank (
		.theClock          (theClock),
		.SPI_counter_reset (SPI_counter_reset),
		.frameDone         (frameDone),
		.frame             (frame),
		.frameAddr         (frameAddr),
		.stepCount         (stepCount),
		.posX              (posX),
		.posY              (posY),
		.readData          (readData),
		.configBits        (configBits),
		.led               (led),
		.pixel             (pixel),
		.irq               (irq)
	);

	cursorTracker #(
		.frameWidth  (frameWidth),
		.frameHeight (frameHeight)
	) tracker (
		.theClock          (theClock),
		.SPI_counter_reset (SPI_counter_reset),
		.stepPulse         (stepPulse),
		.configBits        (configBits),     // Steered by the config register
		.stepCount         (stepCount),
		.posX              (posX),
		.posY              (posY)
	);

endmodule

//--- source/spiRegisterBank.sv
// Register bank behind the SPI slave with write decode, read multiplexer and frame interrupt
`timescale 1ns/10ps

module spiRegisterBank (
	input  logic                     theClock,
	input  logic                     SPI_counter_reset,
	input  logic                     frameDone,
	input  spiPeriphPkg::spiTransfer frame,
	input  spiPeriphPkg::regAddr     frameAddr,
	input  logic [7:0]               stepCount,
	input  logic [7:0]               posX,
	input  logic [7:0]               posY,
	output logic [7:0]               readData,
	output logic [7:0]               configBits,
	output logic [7:0]               led,
	output spiPeriphPkg::pixelRgb    pixel,
	output logic                     irq
);
	import spiPeriphPkg::*;

	logic writeStrobe;

	assign writeStrobe = frameDone & frame.write;

	// Writable registers, read-only and unknown addresses fall through
	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			configBits <= 8'h00;
			led        <= 8'h00;
			pixel      <= '0;
		end
		else if (writeStrobe)
		begin
			case (frame.addr)
				regConfig: configBits  <= frame.data;
				regLed:    led         <= frame.data;
				regPixelR: pixel.red   <= frame.data;
				regPixelG: pixel.green <= frame.data;
				regPixelB: pixel.blue  <= frame.data;
				default:   ;           // Counter and position are tracker owned
			endcase
		end
	end

	// Interrupt one cycle after each complete frame
	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
			irq <= 1'b0;
		else
			irq <= frameDone;
	end

	// Read path, sampled by the slave at the start of the data byte
	always_comb
	begin
		case (frameAddr)
			regConfig:  readData = configBits;
			regCounter: readData = stepCount;
			regPosX:    readData = posX;
			regPosY:    readData = posY;
			regPixelR:  readData = pixel.red;
			regPixelG:  readData = pixel.green;
			regPixelB:  readData = pixel.blue;
			regLed:     readData = led;
			default:    readData = unmappedValue;
		endcase
	end

endmodule

//--- source/spiSerialSlave.sv
// SPI slave front end that decodes one command/data frame per chip-select and returns read data
`timescale 1ns/10ps

module spiSerialSlave (
	input  logic                     theClock,
	input  logic                     SPI_counter_reset,
	input  logic                     spiClk,
	input  logic                     spiCs,
	input  logic                     spiSdi,
	input  logic [7:0]               readData,
	output logic                     spiSdo,
	output logic                     frameDone,
	output spiPeriphPkg::regAddr     frameAddr,
	output spiPeriphPkg::spiTransfer frame
);
	import spiPeriphPkg::*;

	spiState    state;
	spiState    nextState;
	logic       clkMeta;
	logic       clkSync;
	logic       csMeta;
	logic       csSync;
	logic       csLast;
	logic       sdiMeta;
	logic       sdiSync;
	logic       csFall;
	logic       byteDone;
	logic [2:0] bitCount;
	logic [7:0] addrReg;
	logic [7:0] dataReg;

	// Two-flop synchronizers, chip select idles high
	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			clkMeta <= 1'b0;
			clkSync <= 1'b0;
			csMeta  <= 1'b1;
			csSync  <= 1'b1;
			csLast  <= 1'b1;
			sdiMeta <= 1'b0;
			sdiSync <= 1'b0;
		end
		else
		begin
			clkMeta <= spiClk;
			clkSync <= clkMeta;
			csMeta  <= spiCs;
			csSync  <= csMeta;
			csLast  <= csSync;     // Edge detect on synced select
			sdiMeta <= spiSdi;
			sdiSync <= sdiMeta;
		end
	end

	assign csFall   = csLast & ~csSync;   // New frame only on a fresh select
	assign byteDone = (bitCount == 3'd0); // Wrapped after eight shifts

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
			state <= idle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			idle:
			begin
				if (csFall)
					nextState = addrStart;
			end
			addrStart:    nextState = addrWaitHigh;
			addrWaitHigh:
			begin
				if (clkSync)
					nextState = addrShift;
			end
			addrShift:    nextState = addrWaitLow;
			addrWaitLow:
			begin
				if (!clkSync)
					nextState = byteDone ? dataStart : addrWaitHigh;
			end
			dataStart:    nextState = dataWaitHigh;
			dataWaitHigh:
			begin
				if (clkSync)
					nextState = dataShift;
			end
			dataShift:    nextState = dataWaitLow;
			dataWaitLow:
			begin
				if (!clkSync)
					nextState = byteDone ? frameEnd : dataWaitHigh;
			end
			frameEnd:     nextState = idle;
			default:      nextState = idle;
		endcase
		if (csSync)
			nextState = idle;  // Deselect aborts at any point
	end

	// Bit counter and shift registers
	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			bitCount <= 3'd0;
			addrReg  <= 8'h00;
			dataReg  <= 8'h00;
		end
		else
		begin
			if (state == addrStart || state == dataStart)
				bitCount <= 3'd0;
			else if (state == addrShift || state == dataShift)
				bitCount <= bitCount + 3'd1;

			if (state == addrShift)
				addrReg <= {addrReg[6:0], sdiSync};    // Command, MSB first

			if (state == dataStart)
				dataReg <= readData;                   // Old value goes out on sdo
			else if (state == dataShift)
				dataReg <= {dataReg[6:0], sdiSync};
		end
	end

	assign spiSdo     = dataReg[7];
	assign frameAddr  = regAddr'(addrReg[6:0]);
	assign frame      = '{write: addrReg[7], addr: regAddr'(addrReg[6:0]), data: dataReg};
	assign frameDone  = (state == frameEnd) & ~csSync;

endmodule

//--- test/spiPeripheralChecker.sv
// SPI peripheral checker comparing frame results and ports with the model and counting irq pulses
`timescale 1ns/10ps

module spiPeripheralChecker (
	input logic                  theClock,
	input logic                  irq,
	input logic [7:0]            configBits,
	input logic [7:0]            led,
	input spiPeriphPkg::pixelRgb pixel
);
	import spiPeriphPkg::*;

	int    irqCount = 0;
	int    irqMark = 0;
	int    errorCount = 0;
	int    checkCount = 0;
	int    testCount = 0;
	int    testErrors = 0;
	string testName = "";

	always @(posedge theClock)
	begin
		if (irq === 1'b1)
			irqCount <= irqCount + 1;
	end

	task automatic startTest(input string name);
		testName   = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		testCount++;
		$display("test %s: %s (%0d errors)", testName, (testErrors == 0) ? "ok" : "failed",
			testErrors);
	endtask

	task automatic compareByte(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("mismatch %s %s: expected 8'h%02h, actual 8'h%02h", testName, what,
				expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic comparePorts(input logic [7:0] expConfig, input logic [7:0] expLed,
		input pixelRgb expPixel);
		compareByte("config port", expConfig, configBits);
		compareByte("led port", expLed, led);
		compareByte("pixel red", expPixel.red, pixel.red);
		compareByte("pixel green", expPixel.green, pixel.green);
		compareByte("pixel blue", expPixel.blue, pixel.blue);
	endtask

	task automatic markIrq();
		irqMark = irqCount;   // Pulses are counted from here
	endtask

	task automatic expectIrq(input int pulses);
		int waited;
		waited = 0;
		while (irqCount - irqMark < pulses && waited < 200)
		begin
			@(posedge theClock);
			#2;
			waited++;
		end
		checkCount++;
		if (irqCount - irqMark < pulses)
		begin
			$display("%s: no irq pulse arrived within 200 cycles", testName);
			errorCount++;
			testErrors++;
		end
		else
		begin
			repeat (10) @(posedge theClock);   // Window for a stray second pulse
			#2;
			if (irqCount - irqMark != pulses)
			begin
				$display("mismatch %s irq pulses: expected %0d, actual %0d", testName,
					pulses, irqCount - irqMark);
				errorCount++;
				testErrors++;
			end
		end
	endtask

	task automatic reportCounts();
		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
			errorCount);
	endtask

endmodule

//--- test/spiPeripheralTb.sv
// SPI peripheral testbench with a bit-banged SPI master, seeded random frames and a register model
`timescale 1ns/10ps

module spiPeripheralTb;
	import spiPeriphPkg::*;

	localparam int modelWidth  = 8;
	localparam int modelHeight = 4;

	logic       theClock;
	logic       SPI_counter_reset;
	logic       spiClk;
	logic       spiCs;
	logic       spiSdi;
	logic       stepPulse;
	logic       spiSdo;
	logic [7:0] configBits;
	logic [7:0] led;
	pixelRgb    pixel;
	logic       irq;
	integer     seed;
	logic [7:0] mConfig;
	logic [7:0] mLed;
	pixelRgb    mPixel;
	int         mCount;
	int         mX;
	int         mY;

	spiPeripheralTop #(
		.frameWidth  (modelWidth),     // Small frame so wraps occur
		.frameHeight (modelHeight)
	) uut (
		.theClock          (theClock),
		.SPI_counter_reset (SPI_counter_reset),
		.spiClk            (spiClk),
		.spiCs             (spiCs),
		.spiSdi            (spiSdi),
		.stepPulse         (stepPulse),
		.spiSdo            (spiSdo),
		.configBits        (configBits),
		.led               (led),
		.pixel             (pixel),
		.irq               (irq)
	);

	spiPeripheralChecker check (
		.theClock   (theClock),
		.irq        (irq),
		.configBits (configBits),
		.led        (led),
		.pixel      (pixel)
	);

	always #20 theClock = ~theClock;

	task automatic tick(input int n);
		repeat (n) @(posedge theClock);
		#2;                        // Drive just after the edge
	endtask

	function automatic logic [7:0] rand8();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic logic [6:0] pickAddr(input logic [31:0] r);
		case (r % 32'd10)
			0:       return regConfig;
			1:       return regCounter;
			2:       return regPosX;
			3:       return regPosY;
			4:       return regPixelR;
			5:       return regPixelG;
			6:       return regPixelB;
			7:       return regLed;
			8:       return 7'h01;
			default: return {2'b10, r[8:4]};   // 7'h40..7'h5f are all unmapped
		endcase
	endfunction

	function automatic logic [7:0] modelRead(input logic [6:0] a);
		case (a)
			regConfig:  return mConfig;
			regCounter: return 8'(mCount);
			regPosX:    return 8'(mX);
			regPosY:    return 8'(mY);
			regPixelR:  return mPixel.red;
			regPixelG:  return mPixel.green;
			regPixelB:  return mPixel.blue;
			regLed:     return mLed;
			default:    return 8'h0f;
		endcase
	endfunction

	task automatic modelWrite(input logic [6:0] a, input logic [7:0] d);
		case (a)
			regConfig: mConfig      = d;
			regLed:    mLed         = d;
			regPixelR: mPixel.red   = d;
			regPixelG: mPixel.green = d;
			regPixelB: mPixel.blue  = d;
			default:   ;
		endcase
		if (mConfig[1])
		begin
			mCount = 0;
			mX     = 0;
			mY     = 0;
		end
	endtask

	task automatic stepBurst(input int n);
		repeat (n)
		begin
			stepPulse = 1'b1;
			tick(1);
			stepPulse = 1'b0;
			tick(1);
			if (mConfig[0] && !mConfig[1])
			begin
				mCount = (mCount + 1) % 256;
				mX     = (mX + 1) % modelWidth;
				if (mX == 0)
					mY = (mY + 1) % modelHeight;
			end
		end
		tick(4);
	endtask

	// Mode 0 master with 5 clocks per phase that stops early when stopAfter is below 16
	task automatic spiFrame(input logic [15:0] bits, input int stopAfter,
		output logic [7:0] captured);
		logic [15:0] shiftOut;
		shiftOut = bits;
		captured = 8'h00;
		spiCs    = 1'b0;
		tick(5);
		for (int n = 0; n < stopAfter; n++)
		begin
			spiSdi   = shiftOut[15];
			shiftOut = {shiftOut[14:0], 1'b0};
			tick(5);
			if (n >= 8)
				captured = {captured[6:0], spiSdo};   // Sdo read before the rise
			spiClk = 1'b1;
			tick(5);
			spiClk = 1'b0;
		end
		tick(5);
		spiCs  = 1'b1;
		spiSdi = 1'b0;
		tick(5);
	endtask

	task automatic doFrame(input logic wr, input logic [6:0] a, input logic [7:0] d);
		logic [7:0] expected;
		logic [7:0] captured;
		expected = modelRead(a);
		check.markIrq();
		spiFrame({wr, a, d}, 16, captured);
		check.compareByte($sformatf("sdo of 7'h%02h", a), expected, captured);
		if (wr)
			modelWrite(a, d);
		check.expectIrq(1);
		check.comparePorts(mConfig, mLed, mPixel);
	endtask

	task automatic readTracker();
		doFrame(1'b0, regCounter, 8'h00);
		doFrame(1'b0, regPosX, 8'h00);
		doFrame(1'b0, regPosY, 8'h00);
	endtask

	initial
	begin
		logic [31:0] r;
		logic [7:0]  captured;
		int          stopAfter;
		seed              = 32'h0acc_5ecf;
		theClock          = 1'b0;
		SPI_counter_reset = 1'b1;
		spiClk            = 1'b0;
		spiCs             = 1'b1;
		spiSdi            = 1'b0;
		stepPulse         = 1'b0;
		mConfig           = 8'h00;
		mLed              = 8'h00;
		mPixel            = '0;
		mCount            = 0;
		mX                = 0;
		mY                = 0;
		tick(16);
		SPI_counter_reset = 1'b0;
		tick(4);

		check.startTest("resetValues");
		check.markIrq();
		check.expectIrq(0);
		check.comparePorts(8'h00, 8'h00, '0);
		doFrame(1'b0, regConfig, 8'h00);
		doFrame(1'b0, regLed, 8'h00);
		doFrame(1'b0, regPixelR, 8'h00);
		doFrame(1'b0, regPixelG, 8'h00);
		doFrame(1'b0, regPixelB, 8'h00);
		check.finishTest();

		check.startTest("writePorts");
		doFrame(1'b1, regLed, rand8());
		doFrame(1'b1, regPixelR, rand8());
		doFrame(1'b1, regPixelG, rand8());
		doFrame(1'b1, regPixelB, rand8());
		doFrame(1'b1, regConfig, 8'h01);
		check.finishTest();

		check.startTest("randomFrames");
		repeat (40)
		begin
			r = $random(seed);
			doFrame(r[12], pickAddr(r), r[23:16]);
			if (r[31:29] == 3'd0)
				stepBurst(int'(r[27:24]) + 1);
		end
		check.finishTest();

		check.startTest("stepTracking");
		doFrame(1'b1, regConfig, 8'h01);
		repeat (6)
		begin
			r = $random(seed);
			stepBurst(int'(r[4:0]) + 1);
			readTracker();
		end
		doFrame(1'b1, regConfig, 8'h00);   // Steps ignored while disabled
		stepBurst(7);
		readTracker();
		doFrame(1'b1, regConfig, 8'h03);   // Clear beats enable
		stepBurst(3);
		readTracker();
		doFrame(1'b1, regConfig, 8'h01);
		stepBurst(9);
		readTracker();
		check.finishTest();

		check.startTest("abortFrame");
		repeat (4)
		begin
			r         = $random(seed);
			stopAfter = int'(r % 32'd15) + 1;
			if (stopAfter == 8)
				stopAfter = 12;            // Keep the abort inside a byte
			check.markIrq();
			spiFrame({1'b1, pickAddr(r), r[23:16]}, stopAfter, captured);
			check.expectIrq(0);
			check.comparePorts(mConfig, mLed, mPixel);
			doFrame(1'b0, pickAddr(r), 8'h00);
		end
		check.finishTest();

		check.reportCounts();
		if (check.errorCount == 0 && uut.props.assertFailures == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		repeat (200000) @(posedge theClock);
		$display("timeout: regression did not finish within 200000 clocks");
		$display("Regression failed");
		$finish;
	end

endmodule

//--- test/spiPeripheral_props.sv
// SPI peripheral assertions on the frame strobe, interrupt pulse and register bank outputs
`timescale 1ns/10ps

module spiPeripheralProps (
	input logic                  theClock,
	input logic                  SPI_counter_reset,
	input logic                  spiCs,
	input logic                  frameDone,
	input logic                  irq,
	input logic [7:0]            configBits,
	input logic [7:0]            led,
	input spiPeriphPkg::pixelRgb pixel
);

	logic [7:0] csLowRun;          // Consecutive cycles with chip select low
	int         assertFailures = 0;

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset || spiCs)
			csLowRun <= 8'd0;
		else if (csLowRun != 8'hff)
			csLowRun <= csLowRun + 8'd1;
	end

	irqSingleCycle: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		irq |=> !irq)
		else
		begin
			$error("irq stayed high for more than one cycle");
			assertFailures++;
		end

	// Synchronized select held low for at least the shortest possible frame
	strobeOnlySelected: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		frameDone |-> $past(csLowRun) >= 8'd48)
		else
		begin
			$error("frameDone without chip select held low for the whole frame");
			assertFailures++;
		end

	bankOnlyAfterFrame: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		!$past(frameDone) |-> $stable({configBits, led, pixel}))
		else
		begin
			$error("bank output changed without a preceding frameDone");
			assertFailures++;
		end

endmodule

bind spiPeripheralTop spiPeripheralProps props (
	.theClock          (theClock),
	.SPI_counter_reset (SPI_counter_reset),
	.spiCs             (spiCs),
	.frameDone         (frameDone),
	.irq               (irq),
	.configBits        (configBits),
	.led               (led),
	.pixel             (pixel)
);
